// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

    // RV32 major opcodes
    localparam logic [6:0] RV32_LUI_OP   = 7'b0110111;
    localparam logic [6:0] RV32_AUIPC_OP = 7'b0010111;
    localparam logic [6:0] RV32_JAL_OP   = 7'b1101111;
    localparam logic [6:0] RV32_JALR_OP  = 7'b1100111;
    localparam logic [6:0] RV32_BRANCH   = 7'b1100011;
    localparam logic [6:0] RV32_LOAD     = 7'b0000011;
    localparam logic [6:0] RV32_STORE    = 7'b0100011;
    localparam logic [6:0] RV32_OP_IMM   = 7'b0010011;
    localparam logic [6:0] RV32_OP       = 7'b0110011;
    localparam logic [6:0] RV32_AMO      = 7'b0101111;

    // Standard R-type field positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] op;
    } instr_t;

    // Decode record, MSB first
    typedef struct packed {
        logic op_writes_rf;
        logic is_mem_op;
        logic is_byte_op;
        logic is_hex_op;
        logic is_load_op;
        logic is_load_unsigned;
        logic is_store_op;
        logic is_branch_op;
        logic is_jump_op;
        logic op_reads_rf1;
        logic op_reads_rf2;
        logic op_is_auipc;
    } decode_s;

    // Register codes taken from wb_adr_i[3:2]
    localparam logic [1:0] ADDR_INSTR  = 2'd0;
    localparam logic [1:0] ADDR_RESULT = 2'd1;
    localparam logic [1:0] ADDR_STATUS = 2'd2;

    localparam int RESULT_VALID_BIT = 31;
    localparam int DECODE_W         = $bits(decode_s);

    // Valid flag on top, record in the low bits
    function automatic logic [31:0] result_word(input logic    valid,
                                                input decode_s rec);
        logic [31:0] word;
        word                   = '0;
        word[RESULT_VALID_BIT] = valid;
        word[DECODE_W-1:0]     = rec;
        return word;
    endfunction

    function automatic logic [31:0] status_word(input logic [7:0] instr_count,
                                                input logic [7:0] result_count);
        logic [31:0] word;
        word        = '0;
        word[7:0]   = instr_count;
        word[15:8]  = result_count;
        return word;
    endfunction

endpackage

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type         payload_t  = logic [31:0],
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       push_i,
    input  payload_t   push_data_i,
    output logic       full_o,
    input  logic       pop_i,
    output payload_t   pop_data_o,
    output logic       empty_o,
    output logic [7:0] count_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    payload_t         mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [7:0]       count_q;
    logic             push_ok;
    logic             pop_ok;

    assign full_o  = (count_q == 8'(FIFO_DEPTH));
    assign empty_o = (count_q == 8'd0);
    assign count_o = count_q;

    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    // Head entry is visible without a pop
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 8'd1;
                2'b01:   count_q <= count_q - 8'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Producers must respect full
    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
        else $error("sync_fifo: push while full");

    // Consumers must respect empty
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
        else $error("sync_fifo: pop while empty");

endmodule

// File: rtl/cl_decode.sv
`timescale 1ns/1ps

module cl_decode (
    input  rv_decode_pkg::instr_t  instruction_i,
    output rv_decode_pkg::decode_s decode_o
);

    import rv_decode_pkg::*;

    logic op_writes_rf;
    logic mem_op;
    logic byte_op;
    logic hex_op;
    logic load_op;
    logic load_unsigned;
    logic store_op;
    logic branch_op;
    logic jump_op;
    logic reads_rf1;
    logic reads_rf2;
    logic is_auipc;

    // Writes a destination register
    always_comb begin
        unique case (instruction_i.op)
            RV32_LUI_OP, RV32_AUIPC_OP, RV32_JAL_OP, RV32_JALR_OP,
            RV32_LOAD,   RV32_OP,       RV32_OP_IMM, RV32_AMO:
                op_writes_rf = 1'b1;
            default:
                op_writes_rf = 1'b0;
        endcase
    end

    // Data memory access
    always_comb begin
        unique case (instruction_i.op)
            RV32_LOAD, RV32_STORE: mem_op = 1'b1;
            default:               mem_op = 1'b0;
        endcase
    end

    // Access width from funct3[1:0], only meaningful for memory ops
    always_comb begin
        unique case (instruction_i.funct3[1:0])
            2'b00:   byte_op = mem_op;
            default: byte_op = 1'b0;
        endcase
    end

    always_comb begin
        unique case (instruction_i.funct3[1:0])
            2'b01:   hex_op = mem_op;
            default: hex_op = 1'b0;
        endcase
    end

    always_comb begin
        unique case (instruction_i.op)
            RV32_LOAD: load_op = 1'b1;
            default:   load_op = 1'b0;
        endcase
    end

    // LBU and LHU set funct3[2]
    assign load_unsigned = instruction_i.funct3[2] ? load_op : 1'b0;

    always_comb begin
        unique case (instruction_i.op)
            RV32_STORE: store_op = 1'b1;
            default:    store_op = 1'b0;
        endcase
    end

    // Conditional branches only
    always_comb begin
        unique case (instruction_i.op)
            RV32_BRANCH: branch_op = 1'b1;
            default:     branch_op = 1'b0;
        endcase
    end

    always_comb begin
        unique case (instruction_i.op)
            RV32_JAL_OP, RV32_JALR_OP: jump_op = 1'b1;
            default:                   jump_op = 1'b0;
        endcase
    end

    // Source register rs1 is read
    always_comb begin
        unique case (instruction_i.op)
            RV32_JALR_OP, RV32_BRANCH, RV32_LOAD, RV32_STORE,
            RV32_OP,      RV32_OP_IMM, RV32_AMO:
                reads_rf1 = 1'b1;
            default:
                reads_rf1 = 1'b0;
        endcase
    end

    // Source register rs2 is read
    always_comb begin
        unique case (instruction_i.op)
            RV32_BRANCH, RV32_STORE, RV32_OP, RV32_AMO: reads_rf2 = 1'b1;
            default:                                    reads_rf2 = 1'b0;
        endcase
    end

    assign is_auipc = (instruction_i.op == RV32_AUIPC_OP);

    assign decode_o = '{
        op_writes_rf:     op_writes_rf,
        is_mem_op:        mem_op,
        is_byte_op:       byte_op,
        is_hex_op:        hex_op,
        is_load_op:       load_op,
        is_load_unsigned: load_unsigned,
        is_store_op:      store_op,
        is_branch_op:     branch_op,
        is_jump_op:       jump_op,
        op_reads_rf1:     reads_rf1,
        op_reads_rf2:     reads_rf2,
        op_is_auipc:      is_auipc
    };

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rv_decode_pkg::instr_t  instr_i,
    input  logic                   instr_empty_i,
    output logic                   instr_pop_o,
    output rv_decode_pkg::decode_s result_o,
    output logic                   result_push_o,
    input  logic                   result_full_i
);

    import rv_decode_pkg::*;

    decode_s dec_d;
    decode_s rec_q;
    logic    valid_q;
    logic    load;

    cl_decode u_cl_decode (
        .instruction_i (instr_i),
        .decode_o      (dec_d)
    );

    // Held record leaves whenever the result FIFO has room
    assign result_push_o = valid_q && !result_full_i;
    assign result_o      = rec_q;

    // Refill when the register is empty or draining this cycle
    assign load        = !instr_empty_i && (!valid_q || result_push_o);
    assign instr_pop_o = load;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (result_push_o) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rec_q <= dec_d;
        end
    end

    // A stalled record must not change before it is pushed
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_q && result_full_i) |=> (valid_q && $stable(rec_q)))
        else $error("decode_stage: held record changed while stalled");

endmodule

// File: rtl/wb_decode_port.sv
`timescale 1ns/1ps

module wb_decode_port (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [3:0]             wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    input  logic [3:0]             wb_sel_i,
    output logic                   wb_ack_o,
    output logic [31:0]            wb_dat_o,
    output logic                   instr_push_o,
    output rv_decode_pkg::instr_t  instr_data_o,
    input  logic                   instr_full_i,
    input  logic [7:0]             instr_count_i,
    output logic                   result_pop_o,
    input  rv_decode_pkg::decode_s result_data_i,
    input  logic                   result_empty_i,
    input  logic [7:0]             result_count_i
);

    import rv_decode_pkg::*;

    logic [1:0]  adr_code;
    logic        req;
    logic        wr_instr;
    logic        rd_result;
    logic        rd_status;
    logic        ack_d;
    logic        ack_q;
    logic [31:0] rdata_d;
    logic [31:0] dat_q;

    // Byte lanes are ignored since every access moves a full word
    assign adr_code = wb_adr_i[3:2];

    // The cycle with ack out is the tail of the old request and starts nothing new
    assign req = wb_cyc_i && wb_stb_i && !ack_q;

    assign wr_instr  = req && wb_we_i && (adr_code == ADDR_INSTR);
    assign rd_result = req && !wb_we_i && (adr_code == ADDR_RESULT);
    assign rd_status = req && !wb_we_i && (adr_code == ADDR_STATUS);

    assign instr_push_o = wr_instr && !instr_full_i;
    assign instr_data_o = wb_dat_i;
    assign result_pop_o = rd_result && !result_empty_i;

    // Instruction writes wait for space while everything else acks next cycle
    assign ack_d = req && !(wr_instr && instr_full_i);

    always_comb begin
        rdata_d = '0;
        if (result_pop_o) begin
            rdata_d = result_word(1'b1, result_data_i);
        end else if (rd_status) begin
            rdata_d = status_word(instr_count_i, result_count_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= ack_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ack_d) begin
            dat_q <= rdata_d;
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    // Ack only rises while the master still holds its request
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(wb_ack_o) |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_decode_port: ack without a request");

endmodule

// File: rtl/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o
);

    import rv_decode_pkg::*;

    // Instruction side
    logic       instr_push;
    instr_t     instr_wdata;
    logic       instr_full;
    logic       instr_pop;
    instr_t     instr_head;
    logic       instr_empty;
    logic [7:0] instr_count;

    // Result side
    logic       result_push;
    decode_s    result_wdata;
    logic       result_full;
    logic       result_pop;
    decode_s    result_head;
    logic       result_empty;
    logic [7:0] result_count;

    wb_decode_port u_port (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .instr_push_o   (instr_push),
        .instr_data_o   (instr_wdata),
        .instr_full_i   (instr_full),
        .instr_count_i  (instr_count),
        .result_pop_o   (result_pop),
        .result_data_i  (result_head),
        .result_empty_i (result_empty),
        .result_count_i (result_count)
    );

    sync_fifo #(
        .payload_t  (instr_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_instr_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (instr_push),
        .push_data_i (instr_wdata),
        .full_o      (instr_full),
        .pop_i       (instr_pop),
        .pop_data_o  (instr_head),
        .empty_o     (instr_empty),
        .count_o     (instr_count)
    );

    decode_stage u_decode_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_head),
        .instr_empty_i (instr_empty),
        .instr_pop_o   (instr_pop),
        .result_o      (result_wdata),
        .result_push_o (result_push),
        .result_full_i (result_full)
    );

    sync_fifo #(
        .payload_t  (decode_s),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_result_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (result_push),
        .push_data_i (result_wdata),
        .full_o      (result_full),
        .pop_i       (result_pop),
        .pop_data_o  (result_head),
        .empty_o     (result_empty),
        .count_o     (result_count)
    );

endmodule

// File: testbench/tb_rv_decode_top.sv
`timescale 1ns/1ps

module tb_rv_decode_top;

    import rv_decode_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int ACK_LIMIT  = 40;
    localparam int POLL_LIMIT = 40;

    logic        clk_i;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;

    int          errors;
    int          checks;
    logic [31:0] lfsr_q;
    logic [31:0] expected_q [$];

    rv_decode_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    // Index 10 is an opcode the decoder does not know
    function automatic logic [6:0] pick_opcode(input int idx);
        case (idx)
            0:       return RV32_LUI_OP;
            1:       return RV32_AUIPC_OP;
            2:       return RV32_JAL_OP;
            3:       return RV32_JALR_OP;
            4:       return RV32_BRANCH;
            5:       return RV32_LOAD;
            6:       return RV32_STORE;
            7:       return RV32_OP_IMM;
            8:       return RV32_OP;
            9:       return RV32_AMO;
            default: return 7'b1111111;
        endcase
    endfunction

    // Reference decoder, flags MSB first
    function automatic logic [11:0] model_decode(input logic [31:0] instr);
        logic [6:0] op;
        logic [2:0] f3;
        logic       wr;
        logic       mem;
        logic       ld;
        logic       rf1;
        logic       rf2;
        op  = instr[6:0];
        f3  = instr[14:12];
        wr  = op inside {RV32_LUI_OP, RV32_AUIPC_OP, RV32_JAL_OP, RV32_JALR_OP,
                         RV32_LOAD, RV32_OP, RV32_OP_IMM, RV32_AMO};
        mem = (op == RV32_LOAD) || (op == RV32_STORE);
        ld  = (op == RV32_LOAD);
        rf1 = op inside {RV32_JALR_OP, RV32_BRANCH, RV32_LOAD, RV32_STORE,
                         RV32_OP, RV32_OP_IMM, RV32_AMO};
        rf2 = op inside {RV32_BRANCH, RV32_STORE, RV32_OP, RV32_AMO};
        return {wr, mem, mem && (f3[1:0] == 2'b00), mem && (f3[1:0] == 2'b01),
                ld, ld && f3[2], op == RV32_STORE, op == RV32_BRANCH,
                (op == RV32_JAL_OP) || (op == RV32_JALR_OP), rf1, rf2,
                op == RV32_AUIPC_OP};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] instr);
        return {1'b1, 19'd0, model_decode(instr)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic wb_write(input logic [1:0] code, input logic [31:0] data,
                            input bit stall_ok, output bit acked);
        int cycles;
        acked  = 1'b0;
        cycles = 0;
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= {code, 2'b00};
        wb_dat_i <= data;
        wb_sel_i <= 4'hf;
        while (!acked && cycles < ACK_LIMIT) begin
            @(negedge clk_i);
            acked = wb_ack_o;
            cycles++;
        end
        // Drop the request, also when it is abandoned
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        if (!acked && !stall_ok) begin
            errors++;
            $display("ERROR: write of %08h got no ack within %0d cycles", data, ACK_LIMIT);
        end
    endtask

    task automatic wb_read(input logic [1:0] code, output logic [31:0] data);
        int cycles;
        bit acked;
        acked  = 1'b0;
        cycles = 0;
        data   = '0;
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= {code, 2'b00};
        wb_sel_i <= 4'hf;
        while (!acked && cycles < ACK_LIMIT) begin
            @(negedge clk_i);
            acked = wb_ack_o;
            data  = wb_dat_o;
            cycles++;
        end
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        if (!acked) begin
            errors++;
            $display("ERROR: read of register %0d got no ack within %0d cycles", code,
                     ACK_LIMIT);
        end
    endtask

    // Wait until at least one decode record is waiting
    task automatic poll_status();
        logic [31:0] data;
        int          polls;
        data  = '0;
        polls = 0;
        while (data[15:8] == 8'd0 && polls < POLL_LIMIT) begin
            wb_read(ADDR_STATUS, data);
            polls++;
        end
        if (data[15:8] == 8'd0) begin
            errors++;
            $display("ERROR: result count stayed zero for %0d status reads", POLL_LIMIT);
        end
    endtask

    // Results may lag the write, so empty reads are retried
    task automatic read_result(output logic [31:0] data);
        int tries;
        data  = '0;
        tries = 0;
        while (!data[31] && tries < POLL_LIMIT) begin
            wb_read(ADDR_RESULT, data);
            tries++;
        end
        if (!data[31]) begin
            errors++;
            $display("ERROR: no valid result after %0d reads", POLL_LIMIT);
        end
    endtask

    task automatic write_instr(input logic [31:0] instr);
        bit acked;
        wb_write(ADDR_INSTR, instr, 1'b0, acked);
        if (acked) begin
            expected_q.push_back(expected_word(instr));
        end
    endtask

    task automatic drain_and_check(input string name);
        logic [31:0] data;
        while (expected_q.size() > 0) begin
            read_result(data);
            check_value(name, expected_q.pop_front(), data);
        end
    endtask

    // Batches stay below the pipeline capacity of 2*FIFO_DEPTH+1
    task automatic queue_instr(input string name, input logic [31:0] instr);
        write_instr(instr);
        if (expected_q.size() >= 2 * FIFO_DEPTH) begin
            drain_and_check(name);
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        wb_read(ADDR_STATUS, data);
        check_value("reset_status", 32'd0, data);
        wb_read(ADDR_RESULT, data);
        check_value("reset_result", 32'd0, data);
    endtask

    task automatic test_opcode_classes();
        logic [31:0] instr;
        for (int i = 0; i <= 10; i++) begin
            instr = {25'h12a_5c3, pick_opcode(i)};
            write_instr(instr);
            poll_status();
            drain_and_check($sformatf("opcode_%02h", instr[6:0]));
        end
    endtask

    task automatic test_mem_widths();
        logic [31:0] instr;
        logic [6:0]  op;
        for (int m = 0; m < 2; m++) begin
            op = (m == 0) ? RV32_LOAD : RV32_STORE;
            for (int f = 0; f < 8; f++) begin
                instr = {17'h0b2c1, 3'(f), 5'd9, op};
                queue_instr("mem_widths", instr);
            end
        end
        // Width flags stay clear outside loads and stores
        for (int i = 0; i <= 10; i++) begin
            if (i != 5 && i != 6) begin
                instr = {17'h0b2c1, 3'b000, 5'd9, pick_opcode(i)};
                queue_instr("non_mem_funct3", instr);
            end
        end
        drain_and_check("non_mem_funct3");
    endtask

    task automatic test_random_order();
        logic [31:0] sel;
        logic [31:0] rest;
        for (int i = 0; i < 32; i++) begin
            random_bits(4, sel);
            random_bits(25, rest);
            queue_instr("random_order", {rest[24:0], pick_opcode(int'(sel % 32'd10))});
        end
        drain_and_check("random_order");
    endtask

    task automatic test_back_pressure();
        logic [31:0] rest;
        logic [31:0] data;
        bit          acked;
        for (int i = 0; i < 2 * FIFO_DEPTH + 1; i++) begin
            random_bits(25, rest);
            write_instr({rest[24:0], pick_opcode(i % 10)});
        end
        // Pipeline is full, this write must stall
        wb_write(ADDR_INSTR, 32'h0000_0033, 1'b1, acked);
        if (acked) begin
            errors++;
            $display("ERROR: write was accepted while the pipeline was full");
        end
        wb_read(ADDR_STATUS, data);
        check_value("back_pressure_status", {16'd0, 8'(FIFO_DEPTH), 8'(FIFO_DEPTH)}, data);
        drain_and_check("back_pressure_drain");
        wb_read(ADDR_STATUS, data);
        check_value("back_pressure_empty", 32'd0, data);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        lfsr_q   = 32'h0630_2956;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = 4'd0;
        wb_dat_i = 32'd0;
        wb_sel_i = 4'd0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        test_reset_state();
        test_opcode_classes();
        test_mem_widths();
        test_random_order();
        test_back_pressure();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/rv_decode_pkg.sv
rtl/sync_fifo.sv
rtl/cl_decode.sv
rtl/decode_stage.sv
rtl/wb_decode_port.sv
rtl/rv_decode_top.sv
testbench/tb_rv_decode_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --assert --top-module tb_rv_decode_top -f files.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee "$LOG" \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "TEST FAILED" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST OK" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
